/* common/rvExecPkg.sv */
package rvExecPkg;

    // Lane count also bounds the number of operations in flight
    localparam int unsigned NumLanes = 4;
    localparam int unsigned LaneIdxW = 2;

    // RV32I major opcodes seen by the execute stage
    localparam logic [6:0] OpR      = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;

    // ALU selections, zero must stay ADD
    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluSll  = 4'd2,
        AluSlt  = 4'd3,
        AluSltu = 4'd4,
        AluXor  = 4'd5,
        AluSrl  = 4'd6,
        AluSra  = 4'd7,
        AluOr   = 4'd8,
        AluAnd  = 4'd9,
        AluSge  = 4'd10,
        AluSgeu = 4'd11
    } aluSelE;

    // Decoded operation as it enters the stage
    typedef struct packed {
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic        bit30;
        logic [31:0] a;  // rs1
        logic [31:0] b;  // rs2 or immediate, picked upstream
    } execOpS;

    typedef struct packed {
        logic [31:0] value;
        logic        zero;
    } execResultS;

endpackage

/* aluControl/aluControl.sv */
`timescale 1ns/1ps

module aluControl (
    input  logic [6:0]         opcode,
    input  logic [2:0]         funct3,
    input  logic               bit30,
    output rvExecPkg::aluSelE  aluSel
);

    // Shared by R-format and OP-IMM
    function automatic rvExecPkg::aluSelE arithSel(
        input logic [2:0] f3,
        input logic       b30,
        input logic       isReg
    );
        rvExecPkg::aluSelE sel;
        case (f3)
            3'b000: begin
                // Immediate form has no SUB
                sel = (isReg && b30) ? rvExecPkg::AluSub : rvExecPkg::AluAdd;
            end
            3'b001: sel = rvExecPkg::AluSll;
            3'b010: sel = rvExecPkg::AluSlt;
            3'b011: sel = rvExecPkg::AluSltu;
            3'b100: sel = rvExecPkg::AluXor;
            3'b101: sel = b30 ? rvExecPkg::AluSra : rvExecPkg::AluSrl;
            3'b110: sel = rvExecPkg::AluOr;
            default: sel = rvExecPkg::AluAnd;
        endcase
        return sel;
    endfunction

    always_comb begin
        aluSel = rvExecPkg::AluAdd;
        case (opcode)
            rvExecPkg::OpR: begin
                aluSel = arithSel(funct3, bit30, 1'b1);
            end
            rvExecPkg::OpImm: begin
                aluSel = arithSel(funct3, bit30, 1'b0);
            end
            rvExecPkg::OpLoad: begin
                aluSel = rvExecPkg::AluAdd;  // Address add
            end
            rvExecPkg::OpBranch: begin
                case (funct3)
                    3'b000: aluSel = rvExecPkg::AluSub;   // BEQ
                    3'b001: aluSel = rvExecPkg::AluSub;   // BNE
                    3'b100: aluSel = rvExecPkg::AluSlt;
                    3'b101: aluSel = rvExecPkg::AluSge;
                    3'b110: aluSel = rvExecPkg::AluSltu;
                    3'b111: aluSel = rvExecPkg::AluSgeu;
                    default: aluSel = rvExecPkg::AluAdd;
                endcase
            end
            rvExecPkg::OpLui, rvExecPkg::OpAuipc: begin
                aluSel = rvExecPkg::AluAdd;
            end
            // Stores, jumps and unknown codes
            default: aluSel = rvExecPkg::AluAdd;
        endcase
    end

endmodule

/* alu/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  rvExecPkg::aluSelE     aluSel,
    output rvExecPkg::execResultS result
);

    logic [4:0]  shamt;
    logic [31:0] value;
    logic        ltSigned;
    logic        ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluSel)
            rvExecPkg::AluAdd:  value = a + b;
            rvExecPkg::AluSub:  value = a - b;
            rvExecPkg::AluSll:  value = a << shamt;
            rvExecPkg::AluSlt:  value = {31'd0, ltSigned};
            rvExecPkg::AluSltu: value = {31'd0, ltUnsigned};
            rvExecPkg::AluXor:  value = a ^ b;
            rvExecPkg::AluSrl:  value = a >> shamt;
            rvExecPkg::AluSra:  value = $unsigned($signed(a) >>> shamt);
            rvExecPkg::AluOr:   value = a | b;
            rvExecPkg::AluAnd:  value = a & b;
            rvExecPkg::AluSge:  value = {31'd0, !ltSigned};
            rvExecPkg::AluSgeu: value = {31'd0, !ltUnsigned};
            default:            value = a + b;
        endcase
    end

    // Zero flag follows the value for every selection
    assign result.value = value;
    assign result.zero  = (value == 32'd0);

endmodule

/* src/execLane.sv */
`timescale 1ns/1ps

module execLane (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  rvExecPkg::execOpS     inOp,
    output logic                  outValid,
    input  logic                  outReady,
    output rvExecPkg::execResultS outResult
);

    rvExecPkg::execOpS opReg;
    rvExecPkg::aluSelE aluSel;
    logic              full;
    logic              accept;

    assign inReady  = !full || outReady;  // Refill in the cycle the result leaves
    assign accept   = inValid && inReady;
    assign outValid = full;

    always_ff @(posedge clk) begin
        if (accept) opReg <= inOp;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (outReady) begin
            full <= 1'b0;
        end
    end

    aluControl uAluControl (
        .opcode(opReg.opcode),
        .funct3(opReg.funct3),
        .bit30 (opReg.bit30),
        .aluSel(aluSel)
    );

    alu uAlu (
        .a     (opReg.a),
        .b     (opReg.b),
        .aluSel(aluSel),
        .result(outResult)
    );

    // Upstream must hold the operation until this lane takes it
    assert property (@(posedge clk) disable iff (!arstN)
        inValid && !inReady |=> inValid && $stable(inOp));

    // A held result is never overwritten
    assert property (@(posedge clk) disable iff (!arstN)
        full && !outReady |=> full && $stable(opReg));

endmodule

/* src/opDispatcher.sv */
`timescale 1ns/1ps

module opDispatcher (
    input  logic                                              clk,
    input  logic                                              arstN,
    input  logic                                              inValid,
    output logic                                              inReady,
    input  rvExecPkg::execOpS                                 inOp,
    output logic [rvExecPkg::NumLanes-1:0]                    laneValid,
    input  logic [rvExecPkg::NumLanes-1:0]                    laneReady,
    output rvExecPkg::execOpS [rvExecPkg::NumLanes-1:0]       laneOp
);

    logic [rvExecPkg::LaneIdxW-1:0] issuePtr;

    assign inReady = laneReady[issuePtr];

    always_comb begin
        for (int i = 0; i < rvExecPkg::NumLanes; i++) begin
            laneValid[i] = inValid && (issuePtr == rvExecPkg::LaneIdxW'(i));
            laneOp[i]    = (issuePtr == rvExecPkg::LaneIdxW'(i)) ? inOp : '0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issuePtr <= '0;
        end else if (inValid && inReady) begin
            if (issuePtr == rvExecPkg::LaneIdxW'(rvExecPkg::NumLanes - 1)) begin
                issuePtr <= '0;
            end else begin
                issuePtr <= issuePtr + 1'b1;
            end
        end
    end

    // Pointer steps one lane per transfer
    assert property (@(posedge clk) disable iff (!arstN)
        inValid && inReady |=> issuePtr == rvExecPkg::LaneIdxW'(
            (int'($past(issuePtr)) + 1) % rvExecPkg::NumLanes));

endmodule

/* src/resultCollector.sv */
`timescale 1ns/1ps

module resultCollector (
    input  logic                                              clk,
    input  logic                                              arstN,
    input  logic [rvExecPkg::NumLanes-1:0]                    laneValid,
    output logic [rvExecPkg::NumLanes-1:0]                    laneReady,
    input  rvExecPkg::execResultS [rvExecPkg::NumLanes-1:0]   laneResult,
    output logic                                              outValid,
    input  logic                                              outReady,
    output rvExecPkg::execResultS                             outResult
);

    logic [rvExecPkg::LaneIdxW-1:0] drainPtr;

    // Same walk as the dispatcher keeps issue order
    assign outValid  = laneValid[drainPtr];
    assign outResult = laneResult[drainPtr];

    always_comb begin
        for (int i = 0; i < rvExecPkg::NumLanes; i++) begin
            laneReady[i] = outReady && (drainPtr == rvExecPkg::LaneIdxW'(i));
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            drainPtr <= '0;
        end else if (outValid && outReady) begin
            if (drainPtr == rvExecPkg::LaneIdxW'(rvExecPkg::NumLanes - 1)) begin
                drainPtr <= '0;
            end else begin
                drainPtr <= drainPtr + 1'b1;
            end
        end
    end

    // Stalled output must not change under the sink
    assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outResult));

endmodule

/* src/rvExecTop.sv */
`timescale 1ns/1ps

module rvExecTop (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  rvExecPkg::execOpS     inOp,
    output logic                  outValid,
    input  logic                  outReady,
    output rvExecPkg::execResultS outResult
);

    logic [rvExecPkg::NumLanes-1:0]                  laneInValid;
    logic [rvExecPkg::NumLanes-1:0]                  laneInReady;
    rvExecPkg::execOpS [rvExecPkg::NumLanes-1:0]     laneInOp;
    logic [rvExecPkg::NumLanes-1:0]                  laneOutValid;
    logic [rvExecPkg::NumLanes-1:0]                  laneOutReady;
    rvExecPkg::execResultS [rvExecPkg::NumLanes-1:0] laneOutResult;

    opDispatcher uDispatcher (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inOp     (inOp),
        .laneValid(laneInValid),
        .laneReady(laneInReady),
        .laneOp   (laneInOp)
    );

    for (genvar i = 0; i < rvExecPkg::NumLanes; i++) begin : gLane
        execLane uLane (
            .clk      (clk),
            .arstN    (arstN),
            .inValid  (laneInValid[i]),
            .inReady  (laneInReady[i]),
            .inOp     (laneInOp[i]),
            .outValid (laneOutValid[i]),
            .outReady (laneOutReady[i]),
            .outResult(laneOutResult[i])
        );
    end

    resultCollector uCollector (
        .clk       (clk),
        .arstN     (arstN),
        .laneValid (laneOutValid),
        .laneReady (laneOutReady),
        .laneResult(laneOutResult),
        .outValid  (outValid),
        .outReady  (outReady),
        .outResult (outResult)
    );

endmodule

/* verif/rvExecTb.sv */
`timescale 1ns/1ps

module rvExecTb;

    localparam int unsigned Seed       = 32'h1c03_d098;
    localparam int          ResetCycles = 8;

    logic                  clk;
    logic                  arstN;
    logic                  inValid;
    logic                  inReady;
    rvExecPkg::execOpS     inOp;
    logic                  outValid;
    logic                  outReady;
    rvExecPkg::execResultS outResult;

    // Stimulus table, one entry per row in each queue
    string       rowName[$];
    logic [6:0]  rowOpcode[$];
    logic [2:0]  rowFunct3[$];
    logic        rowBit30[$];
    logic [31:0] rowA[$];
    logic [31:0] rowB[$];
    logic [31:0] rowExp[$];

    int errors   = 0;
    int inCount  = 0;
    int outCount = 0;
    int fullSeen = 0;  // Cycles with every lane holding a result

    rvExecTop dut (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inOp     (inOp),
        .outValid (outValid),
        .outReady (outReady),
        .outResult(outResult)
    );

    task automatic addRow(input string name, input logic [6:0] opcode, input logic [2:0] funct3,
                          input logic bit30, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] expValue);
        rowName.push_back(name);
        rowOpcode.push_back(opcode);
        rowFunct3.push_back(funct3);
        rowBit30.push_back(bit30);
        rowA.push_back(a);
        rowB.push_back(b);
        rowExp.push_back(expValue);
    endtask

    task automatic fillTable();
        addRow("addR",      rvExecPkg::OpR,      3'b000, 1'b0, 32'h0000_0005, 32'h0000_0003, 32'h0000_0008);
        addRow("subR",      rvExecPkg::OpR,      3'b000, 1'b1, 32'h0000_0005, 32'h0000_0003, 32'h0000_0002);
        addRow("sllR",      rvExecPkg::OpR,      3'b001, 1'b0, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
        addRow("sltNeg",    rvExecPkg::OpR,      3'b010, 1'b0, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0001);
        addRow("sltuNeg",   rvExecPkg::OpR,      3'b011, 1'b0, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0000);
        addRow("xorR",      rvExecPkg::OpR,      3'b100, 1'b0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
        addRow("orR",       rvExecPkg::OpR,      3'b110, 1'b0, 32'hf0f0_0000, 32'h0000_0f0f, 32'hf0f0_0f0f);
        addRow("andR",      rvExecPkg::OpR,      3'b111, 1'b0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
        addRow("srlR",      rvExecPkg::OpR,      3'b101, 1'b0, 32'h8000_0010, 32'h0000_0004, 32'h0800_0001);
        addRow("sraR",      rvExecPkg::OpR,      3'b101, 1'b1, 32'h8000_0010, 32'h0000_0004, 32'hf800_0001);
        addRow("addiBit30", rvExecPkg::OpImm,    3'b000, 1'b1, 32'h0000_000a, 32'hffff_fffc, 32'h0000_0006);
        addRow("srli",      rvExecPkg::OpImm,    3'b101, 1'b0, 32'hffff_ff00, 32'h0000_0008, 32'h00ff_ffff);
        addRow("srai",      rvExecPkg::OpImm,    3'b101, 1'b1, 32'hffff_ff00, 32'h0000_0008, 32'hffff_ffff);
        addRow("slli",      rvExecPkg::OpImm,    3'b001, 1'b0, 32'h0000_0003, 32'h0000_0002, 32'h0000_000c);
        addRow("loadAdd",   rvExecPkg::OpLoad,   3'b010, 1'b0, 32'h1000_0000, 32'h0000_0010, 32'h1000_0010);
        addRow("beqEqual",  rvExecPkg::OpBranch, 3'b000, 1'b0, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000);
        addRow("bneDiff",   rvExecPkg::OpBranch, 3'b001, 1'b0, 32'h0000_0010, 32'h0000_0003, 32'h0000_000d);
        addRow("bltTrue",   rvExecPkg::OpBranch, 3'b100, 1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0001);
        addRow("bgeFalse",  rvExecPkg::OpBranch, 3'b101, 1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000);
        addRow("bltuFalse", rvExecPkg::OpBranch, 3'b110, 1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000);
        addRow("bgeuTrue",  rvExecPkg::OpBranch, 3'b111, 1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0001);
        addRow("bgeEqual",  rvExecPkg::OpBranch, 3'b101, 1'b0, 32'h0000_0007, 32'h0000_0007, 32'h0000_0001);
        addRow("lui",       rvExecPkg::OpLui,    3'b000, 1'b0, 32'h0000_0000, 32'h1234_5000, 32'h1234_5000);
        addRow("auipc",     rvExecPkg::OpAuipc,  3'b000, 1'b0, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000);
        addRow("store",     7'b0100011,          3'b010, 1'b0, 32'h0000_0100, 32'h0000_0004, 32'h0000_0104);
        addRow("unknownOp", 7'b1111111,          3'b111, 1'b1, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
        addRow("jal",       7'b1101111,          3'b000, 1'b0, 32'h0000_0040, 32'h0000_0004, 32'h0000_0044);
        addRow("branchBad", rvExecPkg::OpBranch, 3'b010, 1'b1, 32'h0000_0009, 32'h0000_0003, 32'h0000_000c);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Random sink back-pressure
    initial begin
        void'($urandom(Seed));
        outReady = 1'b0;
        forever begin
            @(posedge clk);
            #1 outReady = 1'($urandom() % 2);
        end
    end

    // Handshakes are sampled mid-cycle, where all inputs are settled
    initial begin
        int pending;
        int idx;
        forever begin
            @(negedge clk);
            pending = inCount - outCount;
            if (!arstN) begin
                if (outValid !== 1'b0) begin
                    errors++;
                    $display("outValid is high during reset");
                end
            end else begin
                if (outValid !== (pending != 0)) begin
                    errors++;
                    $display("outValid is %b with %0d results pending", outValid, pending);
                end
                if (pending == int'(rvExecPkg::NumLanes)) begin
                    fullSeen++;
                    if (!outReady && inReady) begin
                        errors++;
                        $display("inReady is high while all lanes are full and stalled");
                    end
                end
                if (outValid && outReady) begin
                    idx = outCount;
                    if (idx >= rowName.size()) begin
                        errors++;
                        $display("A result arrived after the last table row");
                    end else begin
                        if (outResult.value !== rowExp[idx]) begin
                            errors++;
                            $display("ERROR %s value: expected %h, actual %h",
                                     rowName[idx], rowExp[idx], outResult.value);
                        end
                        if (outResult.zero !== (rowExp[idx] == 32'd0)) begin
                            errors++;
                            $display("ERROR %s zero: expected %b, actual %b",
                                     rowName[idx], rowExp[idx] == 32'd0, outResult.zero);
                        end
                    end
                    outCount++;
                end
                if (inValid && inReady) inCount++;
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = rowName.size() * 20 + ResetCycles;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, not all results arrived", limit);
        $display("Errors found");
        $finish;
    end

    initial begin
        fillTable();
        arstN   = 1'b0;
        inValid = 1'b0;
        inOp    = '0;
        repeat (ResetCycles) @(posedge clk);
        #1 arstN = 1'b1;

        for (int i = 0; i < rowName.size(); i++) begin
            inOp.opcode = rowOpcode[i];
            inOp.funct3 = rowFunct3[i];
            inOp.bit30  = rowBit30[i];
            inOp.a      = rowA[i];
            inOp.b      = rowB[i];
            inValid     = 1'b1;
            do @(negedge clk); while (!inReady);  // Transfer on the next edge
            @(posedge clk);
            #1;
        end
        inValid = 1'b0;
        inOp    = '0;

        while (outCount < rowName.size()) @(posedge clk);
        repeat (4) @(posedge clk);  // Catch any extra result

        if (fullSeen == 0) begin
            errors++;
            $display("Back-pressure never filled all lanes");
        end
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* rvExec.f */
common/rvExecPkg.sv
aluControl/aluControl.sv
alu/alu.sv
src/execLane.sv
src/opDispatcher.sv
src/resultCollector.sv
src/rvExecTop.sv
verif/rvExecTb.sv

/* Bender.yml */
package:
  name: rvExec

sources:
  - common/rvExecPkg.sv
  - aluControl/aluControl.sv
  - alu/alu.sv
  - src/execLane.sv
  - src/opDispatcher.sv
  - src/resultCollector.sv
  - src/rvExecTop.sv
  - target: test
    files:
      - verif/rvExecTb.sv
